/* sources.f */
+incdir+.
aib_pkg.sv
aib_avmm_csr.sv
aib_tx_path.sv
aib_rx_path.sv
aib_channel.sv
aib_channel_assertions.sv
tb_aib_channel.sv

/* tb_aib_channel.sv */
// AIB channel testbench
`timescale 1ns/100ps
`include "aib_defines.svh"

module tb_aib_channel;
    import aib_pkg::*;

    localparam int unsigned rng_seed   = 32'h846cf5ac;
    localparam chan_id_t    own_chan   = 6'h2a;
    localparam int          tmo_cycles = 20;     // per wait loop

    logic       clk = 1'b0;
    logic       arst_n;
    chan_id_t   channel_id;
    avmm_addr_t avmm_addr;
    avmm_be_t   avmm_be;
    logic       avmm_read;
    logic       avmm_write;
    avmm_data_t avmm_wdata;
    avmm_data_t avmm_rdata;
    logic       avmm_rdatavld;
    logic       avmm_waitreq;
    mac_word_t  data_in;
    mac_word_t  data_out;
    pad_word_t  tx_pad;
    pad_word_t  rx_pad;

    csr_word_t  shadow [`AIB_NUM_CSR];            // expected register contents
    pad_word_t  pad_exp_q [$];
    int         pad_due_q [$];
    mac_word_t  mac_exp_q [$];
    int         mac_due_q [$];
    int         cyc = 0;
    int         chk_cnt = 0;
    int         err_cnt = 0;

    aib_channel dut_i (
        .i_cfg_avmm_clk      (clk),
        .i_m_wr_clk          (clk),
        .i_arst_n            (arst_n),
        .i_channel_id        (channel_id),
        .i_cfg_avmm_addr     (avmm_addr),
        .i_cfg_avmm_byte_en  (avmm_be),
        .i_cfg_avmm_read     (avmm_read),
        .i_cfg_avmm_write    (avmm_write),
        .i_cfg_avmm_wdata    (avmm_wdata),
        .o_cfg_avmm_rdata    (avmm_rdata),
        .o_cfg_avmm_rdatavld (avmm_rdatavld),
        .o_cfg_avmm_waitreq  (avmm_waitreq),
        .i_data_in           (data_in),
        .o_data_out          (data_out),
        .o_tx_pad            (tx_pad),
        .i_rx_pad            (rx_pad)
    );

    always #2 clk = ~clk;                         // 4 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic mac_word_t half_swap(input mac_word_t w, input logic en);
        mac_word_t r;
        r = (w << (`AIB_MAC_W / 2)) | (w >> (`AIB_MAC_W / 2));
        return en ? r : w;
    endfunction

    function automatic pad_word_t ref_tx(input mac_word_t d, input logic swap,
                                         input shift_vec_t sh);
        mac_word_t w;
        pad_word_t p;
        w = half_swap(d, swap);
        p = '0;                                   // lanes -1 and 40 are zero
        for (int k = 0; k < `AIB_PADS; k++) begin
            if (sh[k] && k > 0) begin
                p[2*k +: 2] = w[2*(k-1) +: 2];
            end else if (!sh[k] && k < `AIB_LANES) begin
                p[2*k +: 2] = w[2*k +: 2];
            end
        end
        return p;
    endfunction

    function automatic mac_word_t ref_rx(input pad_word_t p, input logic swap,
                                         input shift_vec_t sh);
        mac_word_t w;
        int        src;
        for (int j = 0; j < `AIB_LANES; j++) begin
            src = sh[j+1] ? j + 1 : j;
            w[2*j +: 2] = p[2*src +: 2];
        end
        return half_swap(w, swap);
    endfunction

    // configuration fields as seen through the shadow registers
    function automatic logic fld_tx_swap();
        return shadow[csr_tx_adapt_0][0];
    endfunction

    function automatic logic fld_rx_swap();
        return shadow[csr_rx_adapt_0][0];
    endfunction

    function automatic logic fld_near();
        return shadow[csr_tx_adapt_1][15:14] == 2'd2;
    endfunction

    function automatic shift_vec_t fld_tx_shift();
        return {shadow[csr_redund_1][8:0], shadow[csr_redund_0]};
    endfunction

    function automatic shift_vec_t fld_rx_shift();
        return {shadow[csr_redund_3][8:0], shadow[csr_redund_2]};
    endfunction

    function automatic avmm_addr_t mk_addr(input chan_id_t ch, input logic [5:0] offs,
                                           input logic [2:0] idx, input logic hi);
        return {ch, offs, idx, hi, 1'($urandom)};   // bit 0 is don't care
    endfunction

    function automatic void shadow_write(input avmm_addr_t a, input avmm_be_t be,
                                         input avmm_data_t wd);
        int base;
        if (a[16:11] != own_chan || a[10:5] != 6'd0) begin
            return;
        end
        base = a[1] ? 16 : 0;
        if (be[0]) begin
            shadow[a[4:2]][base +: 8] = wd[7:0];
        end
        if (be[1]) begin
            shadow[a[4:2]][base+8 +: 8] = wd[15:8];
        end
    endfunction

    function automatic avmm_data_t exp_read(input avmm_addr_t a);
        if (a[10:5] != 6'd0) begin
            return '0;
        end
        return a[1] ? shadow[a[4:2]][31:16] : shadow[a[4:2]][15:0];
    endfunction

    function automatic mac_word_t rand_mac();
        return {16'($urandom), $urandom, $urandom};
    endfunction

    function automatic pad_word_t rand_pad();
        return {18'($urandom), $urandom, $urandom};
    endfunction

    function automatic shift_vec_t rand_shift();
        return {9'($urandom), $urandom};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_mac(input string name, input mac_word_t got, input mac_word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pad(input string name, input pad_word_t got, input pad_word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_avmm(input string name, input avmm_data_t got,
                              input avmm_data_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("failure: %s", msg);
    endtask

    // outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        while (pad_due_q.size() != 0 && pad_due_q[0] == cyc) begin
            check_pad("o_tx_pad", tx_pad, pad_exp_q[0]);
            void'(pad_exp_q.pop_front());
            void'(pad_due_q.pop_front());
        end
        while (mac_due_q.size() != 0 && mac_due_q[0] == cyc) begin
            check_mac("o_data_out", data_out, mac_exp_q[0]);
            void'(mac_exp_q.pop_front());
            void'(mac_due_q.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus and data drivers
    //////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;                                       // drive after the edge
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (avmm_waitreq && n < tmo_cycles) begin
            step();
            n++;
        end
        if (avmm_waitreq) begin
            report_failure("waitreq stayed high, the bus request could not be issued");
        end
    endtask

    task automatic avmm_wr(input avmm_addr_t a, input avmm_be_t be, input avmm_data_t wd);
        wait_not_busy();
        avmm_addr  = a;
        avmm_be    = be;
        avmm_wdata = wd;
        avmm_write = 1'b1;
        step();
        avmm_write = 1'b0;
        shadow_write(a, be, wd);
    endtask

    task automatic read_check(input avmm_addr_t a);
        int  n;
        logic got;
        wait_not_busy();
        avmm_addr = a;
        avmm_read = 1'b1;
        step();
        avmm_read = 1'b0;
        n = 0;
        got = 1'b0;
        while (!got && n < tmo_cycles) begin
            if (avmm_rdatavld) begin
                got = 1'b1;
                check_avmm("o_cfg_avmm_rdata", avmm_rdata, exp_read(a));
            end else begin
                step();
                n++;
            end
        end
        if (!got) begin
            report_failure($sformatf("no read data came back for address %h", a));
        end
    endtask

    task automatic read_ignored(input avmm_addr_t a);
        logic seen;
        wait_not_busy();
        seen = 1'b0;
        avmm_addr = a;
        avmm_read = 1'b1;
        step();
        avmm_read = 1'b0;
        repeat (4) begin
            seen = seen | avmm_rdatavld | avmm_waitreq;
            step();
        end
        if (seen) begin
            report_failure($sformatf("read of another channel at %h got a response", a));
        end
    endtask

    task automatic csr_write32(input csr_idx_e idx, input csr_word_t val);
        avmm_wr(mk_addr(own_chan, 6'd0, idx, 1'b0), 2'b11, val[15:0]);
        avmm_wr(mk_addr(own_chan, 6'd0, idx, 1'b1), 2'b11, val[31:16]);
    endtask

    // other stored bits of each register are kept as they are
    task automatic set_cfg(input logic tx_swap, input logic rx_swap, input logic [1:0] lpbk,
                           input shift_vec_t tx_sh, input shift_vec_t rx_sh);
        avmm_wr(mk_addr(own_chan, 6'd0, csr_rx_adapt_0, 1'b0), 2'b11,
                {shadow[csr_rx_adapt_0][15:1], rx_swap});
        avmm_wr(mk_addr(own_chan, 6'd0, csr_tx_adapt_0, 1'b0), 2'b11,
                {shadow[csr_tx_adapt_0][15:1], tx_swap});
        avmm_wr(mk_addr(own_chan, 6'd0, csr_tx_adapt_1, 1'b0), 2'b11,
                {lpbk, shadow[csr_tx_adapt_1][13:0]});
        csr_write32(csr_redund_0, tx_sh[31:0]);
        avmm_wr(mk_addr(own_chan, 6'd0, csr_redund_1, 1'b0), 2'b11,
                {shadow[csr_redund_1][15:9], tx_sh[40:32]});
        csr_write32(csr_redund_2, rx_sh[31:0]);
        avmm_wr(mk_addr(own_chan, 6'd0, csr_redund_3, 1'b0), 2'b11,
                {shadow[csr_redund_3][15:9], rx_sh[40:32]});
    endtask

    task automatic send_words(input int n);
        mac_word_t d;
        pad_word_t p;
        repeat (n) begin
            d = rand_mac();
            p = rand_pad();
            data_in = d;
            rx_pad  = p;
            pad_exp_q.push_back(ref_tx(d, fld_tx_swap(), fld_tx_shift()));
            pad_due_q.push_back(cyc + 1);
            if (fld_near()) begin
                mac_exp_q.push_back(ref_rx(ref_tx(d, fld_tx_swap(), fld_tx_shift()),
                                           fld_rx_swap(), fld_rx_shift()));
                mac_due_q.push_back(cyc + 2);     // tx and rx register in series
            end else begin
                mac_exp_q.push_back(ref_rx(p, fld_rx_swap(), fld_rx_shift()));
                mac_due_q.push_back(cyc + 1);
            end
            step();
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((pad_due_q.size() != 0 || mac_due_q.size() != 0) && n < tmo_cycles) begin
            step();
            n++;
        end
        if (pad_due_q.size() != 0 || mac_due_q.size() != 0) begin
            report_failure("expected data words were never compared");
            pad_exp_q.delete();
            pad_due_q.delete();
            mac_exp_q.delete();
            mac_due_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %s done, %0d errors", name, err_cnt - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int         t0;
        int         total;
        chan_id_t   other;
        logic [5:0] offs;
        void'($urandom(rng_seed));
        arst_n     = 1'b0;
        channel_id = own_chan;
        avmm_addr  = '0;
        avmm_be    = '0;
        avmm_read  = 1'b0;
        avmm_write = 1'b0;
        avmm_wdata = '0;
        data_in    = '0;
        rx_pad     = '0;
        for (int r = 0; r < `AIB_NUM_CSR; r++) begin
            shadow[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        t0 = err_cnt;
        step();
        step();
        check_bit("o_cfg_avmm_waitreq", avmm_waitreq, 1'b0);
        check_bit("o_cfg_avmm_rdatavld", avmm_rdatavld, 1'b0);
        check_avmm("o_cfg_avmm_rdata", avmm_rdata, '0);
        check_pad("o_tx_pad", tx_pad, '0);
        check_mac("o_data_out", data_out, '0);
        end_test("reset", t0);

        t0 = err_cnt;
        repeat (3) begin
            for (int r = 0; r < 2 * `AIB_NUM_CSR; r++) begin
                avmm_wr(mk_addr(own_chan, 6'd0, 3'(r / 2), r[0]), 2'($urandom),
                        16'($urandom));
            end
            for (int r = 0; r < 2 * `AIB_NUM_CSR; r++) begin
                read_check(mk_addr(own_chan, 6'd0, 3'(r / 2), r[0]));
            end
        end
        for (int r = 0; r < `AIB_NUM_CSR; r++) begin
            other = own_chan ^ 6'($urandom_range(1, 63));
            avmm_wr(mk_addr(other, 6'd0, 3'(r), 1'b0), 2'b11, 16'($urandom));
            read_ignored(mk_addr(other, 6'd0, 3'(r), 1'b1));
            read_check(mk_addr(own_chan, 6'd0, 3'(r), 1'b0));
            offs = 6'($urandom_range(1, 63));     // upper offset bits set
            avmm_wr(mk_addr(own_chan, offs, 3'(r), 1'b1), 2'b11, 16'($urandom));
            read_check(mk_addr(own_chan, offs, 3'(r), 1'($urandom)));
            read_check(mk_addr(own_chan, 6'd0, 3'(r), 1'b1));
        end
        end_test("csr access", t0);

        t0 = err_cnt;
        for (int s = 0; s < 2; s++) begin
            set_cfg(s[0], 1'b0, 2'd0, '0, '0);
            send_words(16);
            drain();
        end
        end_test("tx mapping", t0);

        t0 = err_cnt;
        repeat (6) begin
            set_cfg(1'($urandom), 1'b0, 2'd0, rand_shift(), '0);
            send_words(12);
            drain();
        end
        end_test("tx redundancy", t0);

        t0 = err_cnt;
        for (int s = 0; s < 2; s++) begin
            repeat (3) begin
                set_cfg(1'b0, s[0], 2'd0, '0, rand_shift());
                send_words(12);
                drain();
            end
        end
        end_test("rx path", t0);

        t0 = err_cnt;
        for (int m = 0; m < 6; m++) begin
            // near first, then far and code 3 which act as no loopback
            set_cfg(1'($urandom), 1'($urandom),
                    (m < 4) ? 2'd2 : ((m == 4) ? 2'd1 : 2'd3),
                    rand_shift(), rand_shift());
            send_words(12);
            drain();
        end
        end_test("loopback", t0);

        total = err_cnt + dut_i.csr_i.csr_asrt_i.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt,
                 dut_i.csr_i.csr_asrt_i.fail_cnt);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* aib_channel_assertions.sv */
// AIB configuration bus checks
`timescale 1ns/100ps

module aib_channel_assertions (
    input logic                i_clk,
    input logic                i_arst_n,
    input aib_pkg::avmm_addr_t i_addr,
    input aib_pkg::chan_id_t   i_channel_id,
    input logic                i_read,
    input logic                i_waitreq,
    input logic                i_rdatavld
);

    int unsigned fail_cnt = 0;  // failed assertions so far
    logic        rd_taken;      // read taken at this edge

    // accepted when the channel matches and no read is waiting
    assign rd_taken = i_read && (i_addr[16:11] == i_channel_id) && !i_waitreq;

    //////////////////////////////////////////////////////////////////////
    // read handshake timing
    //////////////////////////////////////////////////////////////////////

    a_rdatavld_after_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rd_taken |-> ##2 i_rdatavld)
        else begin
            $error("rdatavld missing two cycles after an accepted read");
            fail_cnt = fail_cnt + 1;
        end

    a_rdatavld_only_after_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_rdatavld |-> $past(rd_taken, 2))
        else begin
            $error("rdatavld without an accepted read two cycles before");
            fail_cnt = fail_cnt + 1;
        end

    a_waitreq_follows_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rd_taken |=> i_waitreq)
        else begin
            $error("waitreq missing in the cycle after an accepted read");
            fail_cnt = fail_cnt + 1;
        end

    a_waitreq_after_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_waitreq |-> $past(rd_taken))
        else begin
            $error("waitreq high outside the cycle after an accepted read");
            fail_cnt = fail_cnt + 1;
        end

    a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_waitreq && i_rdatavld))
        else begin
            $error("waitreq and rdatavld high together");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind aib_avmm_csr aib_channel_assertions csr_asrt_i (
    .i_clk        (i_cfg_avmm_clk),
    .i_arst_n     (i_arst_n),
    .i_addr       (i_cfg_avmm_addr),
    .i_channel_id (i_channel_id),
    .i_read       (i_cfg_avmm_read),
    .i_waitreq    (o_cfg_avmm_waitreq),
    .i_rdatavld   (o_cfg_avmm_rdatavld)
);

/* aib_channel.sv */
// AIB channel top level
`timescale 1ns/100ps

module aib_channel (
    input  logic                i_cfg_avmm_clk,
    input  logic                i_m_wr_clk,
    input  logic                i_arst_n,       // shared by both clock domains

    input  aib_pkg::chan_id_t   i_channel_id,
    input  aib_pkg::avmm_addr_t i_cfg_avmm_addr,
    input  aib_pkg::avmm_be_t   i_cfg_avmm_byte_en,
    input  logic                i_cfg_avmm_read,
    input  logic                i_cfg_avmm_write,
    input  aib_pkg::avmm_data_t i_cfg_avmm_wdata,
    output aib_pkg::avmm_data_t o_cfg_avmm_rdata,
    output logic                o_cfg_avmm_rdatavld,
    output logic                o_cfg_avmm_waitreq,

    input  aib_pkg::mac_word_t  i_data_in,
    output aib_pkg::mac_word_t  o_data_out,
    output aib_pkg::pad_word_t  o_tx_pad,
    input  aib_pkg::pad_word_t  i_rx_pad
);
    import aib_pkg::*;

    // csr fields are quasi static into the data clock
    logic       tx_swap_en;
    logic       rx_swap_en;
    lpbk_mode_e lpbk_mode;
    shift_vec_t tx_shift;
    shift_vec_t rx_shift;

    //////////////////////////////////////////////////////////////////////
    // configuration block
    //////////////////////////////////////////////////////////////////////

    aib_avmm_csr csr_i (
        .i_cfg_avmm_clk      (i_cfg_avmm_clk),
        .i_arst_n            (i_arst_n),
        .i_channel_id        (i_channel_id),
        .i_cfg_avmm_addr     (i_cfg_avmm_addr),
        .i_cfg_avmm_byte_en  (i_cfg_avmm_byte_en),
        .i_cfg_avmm_read     (i_cfg_avmm_read),
        .i_cfg_avmm_write    (i_cfg_avmm_write),
        .i_cfg_avmm_wdata    (i_cfg_avmm_wdata),
        .o_cfg_avmm_rdata    (o_cfg_avmm_rdata),
        .o_cfg_avmm_rdatavld (o_cfg_avmm_rdatavld),
        .o_cfg_avmm_waitreq  (o_cfg_avmm_waitreq),
        .o_tx_swap_en        (tx_swap_en),
        .o_rx_swap_en        (rx_swap_en),
        .o_lpbk_mode         (lpbk_mode),
        .o_tx_shift          (tx_shift),
        .o_rx_shift          (rx_shift)
    );

    //////////////////////////////////////////////////////////////////////
    // data paths
    //////////////////////////////////////////////////////////////////////

    aib_tx_path tx_i (
        .i_m_wr_clk   (i_m_wr_clk),
        .i_arst_n     (i_arst_n),
        .i_tx_swap_en (tx_swap_en),
        .i_data_in    (i_data_in),
        .i_tx_shift   (tx_shift),
        .o_tx_pad     (o_tx_pad)          // also the near loopback source
    );

    aib_rx_path rx_i (
        .i_m_wr_clk   (i_m_wr_clk),
        .i_arst_n     (i_arst_n),
        .i_rx_swap_en (rx_swap_en),
        .i_lpbk_mode  (lpbk_mode),
        .i_rx_pad     (i_rx_pad),
        .i_tx_pad     (o_tx_pad),
        .i_rx_shift   (rx_shift),
        .o_data_out   (o_data_out)
    );

endmodule

/* aib_rx_path.sv */
// AIB channel receive data path
`timescale 1ns/100ps
`include "aib_defines.svh"

module aib_rx_path (
    input  logic                i_m_wr_clk,
    input  logic                i_arst_n,
    input  logic                i_rx_swap_en,
    input  aib_pkg::lpbk_mode_e i_lpbk_mode,
    input  aib_pkg::pad_word_t  i_rx_pad,     // far side pads
    input  aib_pkg::pad_word_t  i_tx_pad,     // own tx pads for near loopback
    input  aib_pkg::shift_vec_t i_rx_shift,   // bit 0 has no lane below it
    output aib_pkg::mac_word_t  o_data_out    // registered word to the mac
);
    import aib_pkg::*;

    pad_word_t  pad_src;
    logic [1:0] rx_pad [`AIB_PADS];           // pad pairs incl spare
    mac_word_t  mrg_word;
    mac_word_t  swp_word;

    //////////////////////////////////////////////////////////////////////
    // loopback select
    //////////////////////////////////////////////////////////////////////

    // far side code falls back to normal receive
    assign pad_src = (i_lpbk_mode == lpbk_near) ? i_tx_pad : i_rx_pad;

    always_comb begin
        for (int p = 0; p < `AIB_PADS; p++) begin
            rx_pad[p] = pad_src[2*p +: 2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // redundancy unshift and lane merge
    //////////////////////////////////////////////////////////////////////

    // lane j comes from the pad above when that pad carries the shift,
    // the mirror of the tx steering
    always_comb begin
        for (int j = 0; j < `AIB_LANES; j++) begin
            if (i_rx_shift[j+1]) begin
                mrg_word[2*j +: 2] = rx_pad[j+1];
            end else begin
                mrg_word[2*j +: 2] = rx_pad[j];
            end
        end
    end

    assign swp_word = swap_halves(mrg_word, i_rx_swap_en);

    always_ff @(posedge i_m_wr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_data_out <= '0;
        end else begin
            o_data_out <= swp_word;           // one cycle from pad word
        end
    end

endmodule

/* aib_tx_path.sv */
// AIB channel transmit data path
`timescale 1ns/100ps
`include "aib_defines.svh"

module aib_tx_path (
    input  logic                i_m_wr_clk,
    input  logic                i_arst_n,
    input  logic                i_tx_swap_en,
    input  aib_pkg::mac_word_t  i_data_in,    // word from the mac
    input  aib_pkg::shift_vec_t i_tx_shift,   // redundancy shift per pad pair
    output aib_pkg::pad_word_t  o_tx_pad      // registered word to the pads
);
    import aib_pkg::*;

    mac_word_t  swp_word;
    logic [1:0] tx_lane [-1:`AIB_LANES];      // zero guard lanes at both ends
    pad_word_t  pad_d;

    //////////////////////////////////////////////////////////////////////
    // half swap and lane split
    //////////////////////////////////////////////////////////////////////

    assign swp_word = swap_halves(i_data_in, i_tx_swap_en);

    always_comb begin
        tx_lane[-1]         = 2'b00;          // feeds pad 0 when shifted
        tx_lane[`AIB_LANES] = 2'b00;          // spare pad when unshifted
        for (int i = 0; i < `AIB_LANES; i++) begin
            tx_lane[i] = swp_word[2*i +: 2];  // even bit on first edge
        end
    end

    //////////////////////////////////////////////////////////////////////
    // redundancy shift
    //////////////////////////////////////////////////////////////////////

    // a set shift bit moves the lane below up onto this pad pair,
    // so everything above a bad pad slides one place toward the spare
    always_comb begin
        for (int p = 0; p < `AIB_PADS; p++) begin
            if (i_tx_shift[p]) begin
                pad_d[2*p +: 2] = tx_lane[p-1];
            end else begin
                pad_d[2*p +: 2] = tx_lane[p];
            end
        end
    end

    always_ff @(posedge i_m_wr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_tx_pad <= '0;
        end else begin
            o_tx_pad <= pad_d;                // one cycle from mac word
        end
    end

endmodule

/* aib_avmm_csr.sv */
// AIB channel configuration registers
`timescale 1ns/100ps
`include "aib_defines.svh"

module aib_avmm_csr (
    input  logic                i_cfg_avmm_clk,
    input  logic                i_arst_n,
    input  aib_pkg::chan_id_t   i_channel_id,         // id this channel answers to
    input  aib_pkg::avmm_addr_t i_cfg_avmm_addr,
    input  aib_pkg::avmm_be_t   i_cfg_avmm_byte_en,
    input  logic                i_cfg_avmm_read,
    input  logic                i_cfg_avmm_write,
    input  aib_pkg::avmm_data_t i_cfg_avmm_wdata,
    output aib_pkg::avmm_data_t o_cfg_avmm_rdata,
    output logic                o_cfg_avmm_rdatavld,
    output logic                o_cfg_avmm_waitreq,   // one wait state per read
    output logic                o_tx_swap_en,
    output logic                o_rx_swap_en,
    output aib_pkg::lpbk_mode_e o_lpbk_mode,
    output aib_pkg::shift_vec_t o_tx_shift,
    output aib_pkg::shift_vec_t o_rx_shift
);
    import aib_pkg::*;

    csr_word_t  csr_q [`AIB_NUM_CSR];   // register file
    logic       chan_hit;
    logic       offs_ok;
    csr_idx_e   reg_sel;
    logic       hi_sel;
    logic       wr_acc;
    logic       rd_acc;
    avmm_data_t rd_mux;
    avmm_data_t rd_buf;                 // read data held over the wait state

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign chan_hit = (i_cfg_avmm_addr[`AIB_AVMM_ADDR_W-1 -: `AIB_CHAN_W] == i_channel_id);
    assign offs_ok  = (i_cfg_avmm_addr[10:5] == '0);   // upper offset must be clear
    assign reg_sel  = csr_idx_e'(i_cfg_avmm_addr[4:2]);
    assign hi_sel   = i_cfg_avmm_addr[1];               // bit 0 is ignored

    // a request is taken only while no read is waiting
    assign wr_acc = i_cfg_avmm_write & chan_hit & ~o_cfg_avmm_waitreq;
    assign rd_acc = i_cfg_avmm_read & chan_hit & ~o_cfg_avmm_waitreq;

    always_comb begin
        rd_mux = '0;                    // out of range offsets read as zero
        if (offs_ok) begin
            if (hi_sel) begin
                rd_mux = csr_q[reg_sel][31:16];
            end else begin
                rd_mux = csr_q[reg_sel][15:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register file with byte enables
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_cfg_avmm_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < `AIB_NUM_CSR; r++) begin
                csr_q[r] <= '0;
            end
        end else if (wr_acc && offs_ok) begin
            for (int b = 0; b < `AIB_AVMM_DATA_W/8; b++) begin
                if (i_cfg_avmm_byte_en[b]) begin
                    // half select picks 31:16 or 15:0, byte within it
                    csr_q[reg_sel][{hi_sel, b[0], 3'b000} +: 8] <= i_cfg_avmm_wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read handshake
    //////////////////////////////////////////////////////////////////////

    // accepted read at edge n
    //   waitreq high after n
    //   rdatavld and rdata after n+1
    always_ff @(posedge i_cfg_avmm_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cfg_avmm_waitreq  <= 1'b0;
            o_cfg_avmm_rdatavld <= 1'b0;
            o_cfg_avmm_rdata    <= '0;
            rd_buf              <= '0;
        end else begin
            o_cfg_avmm_waitreq  <= rd_acc;
            o_cfg_avmm_rdatavld <= o_cfg_avmm_waitreq;   // follows the wait state
            if (rd_acc) begin
                rd_buf <= rd_mux;
            end
            if (o_cfg_avmm_waitreq) begin
                o_cfg_avmm_rdata <= rd_buf;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // configuration fields
    //////////////////////////////////////////////////////////////////////

    // other adapter bits stay stored and readable but drive nothing here
    assign o_tx_swap_en = csr_q[csr_tx_adapt_0][0];
    assign o_rx_swap_en = csr_q[csr_rx_adapt_0][0];
    assign o_lpbk_mode  = lpbk_mode_e'(csr_q[csr_tx_adapt_1][15:14]);

    // shift enables for 41 pad pairs span two registers
    assign o_tx_shift = {csr_q[csr_redund_1][8:0], csr_q[csr_redund_0]};
    assign o_rx_shift = {csr_q[csr_redund_3][8:0], csr_q[csr_redund_2]};

endmodule

/* aib_pkg.sv */
// AIB channel shared types
`include "aib_defines.svh"

package aib_pkg;

    // lane i sits on bits 2i+1:2i, even bit goes out on the first edge
    typedef logic [`AIB_MAC_W-1:0]       mac_word_t;
    typedef logic [`AIB_PAD_W-1:0]       pad_word_t;   // pad pair p on bits 2p+1:2p
    typedef logic [`AIB_PADS-1:0]        shift_vec_t;  // one enable per pad pair

    typedef logic [`AIB_CSR_W-1:0]       csr_word_t;
    typedef logic [`AIB_AVMM_ADDR_W-1:0] avmm_addr_t;
    typedef logic [`AIB_AVMM_DATA_W-1:0] avmm_data_t;
    typedef logic [`AIB_AVMM_DATA_W/8-1:0] avmm_be_t;
    typedef logic [`AIB_CHAN_W-1:0]      chan_id_t;

    // far side and code 3 are handled like no loopback
    typedef enum logic [1:0] {
        lpbk_none = 2'd0,
        lpbk_far  = 2'd1,
        lpbk_near = 2'd2
    } lpbk_mode_e;

    typedef enum logic [2:0] {
        csr_rx_adapt_0 = 3'd0,
        csr_rx_adapt_1 = 3'd1,
        csr_tx_adapt_0 = 3'd2,
        csr_tx_adapt_1 = 3'd3,
        csr_redund_0   = 3'd4,   // tx shift 31:0
        csr_redund_1   = 3'd5,   // tx shift 40:32
        csr_redund_2   = 3'd6,   // rx shift 31:0
        csr_redund_3   = 3'd7    // rx shift 40:32
    } csr_idx_e;

    // exchanges the upper and lower halves of a mac word when en is set
    function automatic mac_word_t swap_halves(input mac_word_t word, input logic en);
        mac_word_t res;
        res = en ? {word[`AIB_MAC_W/2-1:0], word[`AIB_MAC_W-1:`AIB_MAC_W/2]} : word;
        return res;
    endfunction

endpackage

/* aib_defines.svh */
// AIB channel widths and counts
`ifndef AIB_DEFINES_SVH
`define AIB_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// data path
//////////////////////////////////////////////////////////////////////

`define AIB_LANES        40     // ddr lanes per direction
`define AIB_PADS         41     // pad pairs incl the spare
`define AIB_MAC_W        80     // mac side word
`define AIB_PAD_W        82     // pad side word

//////////////////////////////////////////////////////////////////////
// configuration bus
//////////////////////////////////////////////////////////////////////

`define AIB_CHAN_W       6      // channel id in addr 16:11
`define AIB_AVMM_ADDR_W  17
`define AIB_AVMM_DATA_W  16
`define AIB_CSR_W        32
`define AIB_NUM_CSR      8      // rx adapt, tx adapt, redundancy

`endif
